//--- Makefile
VERILATOR ?= verilator
TOP       := tb_floo_ni
FLIST     := flist.f
VFLAGS    := --binary --timing --top-module $(TOP)

BIN  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

//--- dv/floo_ni_stim.txt
# Fields in hex. T bp starts a test, bp 1 gives random readies
# W id addr len data0 dst (AW burst, beat k carries data0+k) | A id addr len dst
# B id resp | R id data resp last
T 0
W 1 00001000 3 A0000000 1
W 2 18000040 0 B0000000 2
W 3 3FFFFFFC 1 C0000000 5
T 0
A 4 80000000 7 9
A 5 0FFFFFFC 0 1
A 6 20000000 3 5
T 0
W 7 50000000 1 D0000000 F
A 8 C0000000 0 F
A 9 90000000 0 F
W A 40000000 0 D1000000 F
T 0
B 1 0
B 2 2
R 4 11111111 0 0
R 4 22222222 0 1
R 5 33333333 1 1
T 1
W 1 00000010 3 E0000000 1
A 2 10000000 1 2
W 3 80000100 2 E1000000 9
A 4 2000FF00 0 5
W 5 FFFF0000 0 E2000000 F
A 6 0000ABC0 2 1
A 7 8FFFFFF0 0 9
W 8 30000000 4 E3000000 5
B 3 0
R 6 44444444 0 0
R 6 55555555 0 1
B 5 3

//--- dv/tb_floo_ni.sv
//////////////////////////////////////////////////////////////////////
// Network interface testbench
// Drives AXI requests and response flits from a stimulus file and
// checks the request link and the AXI B and R channels
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_floo_ni;

  import axi_types_pkg::*;
  import floo_noc_pkg::*;

  localparam int       TimeoutCycles = 2000;
  localparam node_id_t SrcNode       = 4'd3;

  logic      clk_i;
  logic      reset_i;
  node_id_t  id_i;
  axi_aw_t   aw_i;
  logic      aw_valid_i;
  logic      aw_ready_o;
  axi_w_t    w_i;
  logic      w_valid_i;
  logic      w_ready_o;
  axi_ar_t   ar_i;
  logic      ar_valid_i;
  logic      ar_ready_o;
  axi_b_t    b_o;
  logic      b_valid_o;
  logic      b_ready_i;
  axi_r_t    r_o;
  logic      r_valid_o;
  logic      r_ready_i;
  req_flit_t req_flit_o;
  logic      req_valid_o;
  logic      req_ready_i;
  rsp_flit_t rsp_flit_i;
  logic      rsp_valid_i;
  logic      rsp_ready_o;

  // Stimulus of the current test
  axi_aw_t     aw_q[$];
  logic [31:0] d0_q[$];
  axi_ar_t     ar_q[$];
  rsp_flit_t   rsp_q[$];
  // Expected and observed traffic
  req_flit_t   exp_aww[$];
  req_flit_t   exp_ar[$];
  axi_b_t      exp_b[$];
  axi_r_t      exp_r[$];
  req_flit_t   got_req[$];
  axi_b_t      got_b[$];
  axi_r_t      got_r[$];

  int   errors = 0;
  int   test_num = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;
  logic bp_en = 1'b0;
  logic drivers_done = 1'b0;

  floo_ni_top dut0 (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .id_i        ( id_i        ),
    .aw_i        ( aw_i        ),
    .aw_valid_i  ( aw_valid_i  ),
    .aw_ready_o  ( aw_ready_o  ),
    .w_i         ( w_i         ),
    .w_valid_i   ( w_valid_i   ),
    .w_ready_o   ( w_ready_o   ),
    .ar_i        ( ar_i        ),
    .ar_valid_i  ( ar_valid_i  ),
    .ar_ready_o  ( ar_ready_o  ),
    .b_o         ( b_o         ),
    .b_valid_o   ( b_valid_o   ),
    .b_ready_i   ( b_ready_i   ),
    .r_o         ( r_o         ),
    .r_valid_o   ( r_valid_o   ),
    .r_ready_i   ( r_ready_i   ),
    .req_flit_o  ( req_flit_o  ),
    .req_valid_o ( req_valid_o ),
    .req_ready_i ( req_ready_i ),
    .rsp_flit_i  ( rsp_flit_i  ),
    .rsp_valid_i ( rsp_valid_i ),
    .rsp_ready_o ( rsp_ready_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Inputs only change on the rising edge, so transfers are seen here
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (req_valid_o && req_ready_i) begin
        got_req.push_back(req_flit_o);
      end
      if (b_valid_o && b_ready_i) begin
        got_b.push_back(b_o);
      end
      if (r_valid_o && r_ready_i) begin
        got_r.push_back(r_o);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Expected traffic from the stimulus lines
  //////////////////////////////////////////////////////////////////////

  task automatic add_write(input logic [31:0] id, addr, len, data0, dst);
    axi_aw_t   aw;
    axi_w_t    w;
    req_flit_t fl;
    int        k;
    aw = '{id: 4'(id), addr: addr, len: 8'(len)};
    aw_q.push_back(aw);
    d0_q.push_back(data0);
    fl.hdr = '{dst_id: 4'(dst), src_id: SrcNode, axi_ch: AxiAw, last: 1'b0};
    fl.payload = ReqPayloadWidth'(aw);
    exp_aww.push_back(fl);
    // Beat k carries data0 + k and the final beat alone has last
    for (k = 0; k <= int'(aw.len); k++) begin
      w.data = data0 + 32'(k);
      w.strb = '1;
      w.last = (k == int'(aw.len));
      fl.hdr.axi_ch = AxiW;
      fl.hdr.last = w.last;
      fl.payload = ReqPayloadWidth'(w);
      exp_aww.push_back(fl);
    end
  endtask

  task automatic add_read(input logic [31:0] id, addr, len, dst);
    axi_ar_t   ar;
    req_flit_t fl;
    ar = '{id: 4'(id), addr: addr, len: 8'(len)};
    ar_q.push_back(ar);
    fl.hdr = '{dst_id: 4'(dst), src_id: SrcNode, axi_ch: AxiAr, last: 1'b1};
    fl.payload = ReqPayloadWidth'(ar);
    exp_ar.push_back(fl);
  endtask

  task automatic add_b(input logic [31:0] id, resp);
    axi_b_t    b;
    rsp_flit_t fl;
    b = '{id: 4'(id), resp: 2'(resp)};
    exp_b.push_back(b);
    fl.hdr = '{dst_id: SrcNode, src_id: 4'd0, axi_ch: AxiB, last: 1'b1};
    fl.payload = RspPayloadWidth'(b);
    rsp_q.push_back(fl);
  endtask

  task automatic add_r(input logic [31:0] id, data, resp, last);
    axi_r_t    r;
    rsp_flit_t fl;
    r = '{id: 4'(id), data: data, resp: 2'(resp), last: last[0]};
    exp_r.push_back(r);
    fl.hdr = '{dst_id: SrcNode, src_id: 4'd0, axi_ch: AxiR, last: last[0]};
    fl.payload = RspPayloadWidth'(r);
    rsp_q.push_back(fl);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  // Returns on the rising edge where the handshake of channel ch happens
  task automatic wait_ready(input int ch);
    int   cycles;
    logic rdy;
    cycles = 0;
    rdy = 1'b0;
    while (!rdy && cycles < TimeoutCycles) begin
      @(negedge clk_i);
      case (ch)
        0: rdy = aw_ready_o;
        1: rdy = w_ready_o;
        2: rdy = ar_ready_o;
        default: rdy = rsp_ready_o;
      endcase
      cycles++;
    end
    if (!rdy) begin
      $display("Timeout: channel %0d (0 AW, 1 W, 2 AR, 3 response) was never ready", ch);
      errors++;
    end
    @(posedge clk_i);
  endtask

  task automatic drive_writes();
    axi_w_t w;
    int     k;
    @(posedge clk_i);
    foreach (aw_q[i]) begin
      aw_i <= aw_q[i];
      aw_valid_i <= 1'b1;
      wait_ready(0);
      aw_valid_i <= 1'b0;
      // Address bus goes idle while the W beats are sent
      aw_i <= '0;
      for (k = 0; k <= int'(aw_q[i].len); k++) begin
        w.data = d0_q[i] + 32'(k);
        w.strb = '1;
        w.last = (k == int'(aw_q[i].len));
        w_i <= w;
        w_valid_i <= 1'b1;
        wait_ready(1);
      end
      w_valid_i <= 1'b0;
    end
  endtask

  task automatic drive_reads();
    @(posedge clk_i);
    foreach (ar_q[i]) begin
      ar_i <= ar_q[i];
      ar_valid_i <= 1'b1;
      wait_ready(2);
    end
    ar_valid_i <= 1'b0;
  endtask

  task automatic drive_rsps();
    @(posedge clk_i);
    foreach (rsp_q[i]) begin
      rsp_flit_i <= rsp_q[i];
      rsp_valid_i <= 1'b1;
      wait_ready(3);
    end
    rsp_valid_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_requests(input int n_req);
    req_flit_t fl;
    req_flit_t want;
    bit        in_pkt;
    in_pkt = 1'b0;
    assert (got_req.size() == n_req) else begin
      $display("Fail %0t: %0d request flits seen, %0d expected", $time, got_req.size(), n_req);
      errors++;
    end
    foreach (got_req[i]) begin
      fl = got_req[i];
      if (fl.hdr.axi_ch == AxiAr) begin
        assert (!in_pkt) else begin
          $display("Fail %0t: AR flit %h inside a write packet", $time, fl);
          errors++;
        end
        assert (exp_ar.size() > 0) else begin
          $display("Fail %0t: unexpected AR flit %h", $time, fl);
          errors++;
        end
        if (exp_ar.size() > 0) begin
          want = exp_ar.pop_front();
          assert (fl == want) else begin
            $display("Fail %0t: AR flit %h, expected %h", $time, fl, want);
            errors++;
          end
        end
      end else begin
        assert (exp_aww.size() > 0) else begin
          $display("Fail %0t: unexpected write flit %h", $time, fl);
          errors++;
        end
        if (exp_aww.size() > 0) begin
          want = exp_aww.pop_front();
          assert (fl == want) else begin
            $display("Fail %0t: write flit %h, expected %h", $time, fl, want);
            errors++;
          end
        end
        if (fl.hdr.axi_ch == AxiAw) begin
          in_pkt = 1'b1;
        end else if (fl.hdr.last) begin
          in_pkt = 1'b0;
        end
      end
    end
  endtask

  task automatic check_responses();
    assert (got_b.size() == exp_b.size() && got_r.size() == exp_r.size()) else begin
      $display("Fail %0t: %0d B and %0d R beats seen, %0d and %0d expected", $time,
               got_b.size(), got_r.size(), exp_b.size(), exp_r.size());
      errors++;
    end
    foreach (got_b[i]) begin
      if (i < exp_b.size()) begin
        assert (got_b[i] == exp_b[i]) else begin
          $display("Fail %0t: B beat %0d is %h, expected %h", $time, i, got_b[i], exp_b[i]);
          errors++;
        end
      end
    end
    foreach (got_r[i]) begin
      if (i < exp_r.size()) begin
        assert (got_r[i] == exp_r[i]) else begin
          $display("Fail %0t: R beat %0d is %h, expected %h", $time, i, got_r[i], exp_r[i]);
          errors++;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequencing
  //////////////////////////////////////////////////////////////////////

  task automatic run_test();
    int n_req;
    int n_rsp;
    int cycles;
    int errs_at_start;
    n_req = exp_aww.size() + exp_ar.size();
    n_rsp = exp_b.size() + exp_r.size();
    errs_at_start = errors;
    test_num++;
    got_req.delete();
    got_b.delete();
    got_r.delete();
    drivers_done = 1'b0;
    fork
      begin
        fork
          drive_writes();
          drive_reads();
          drive_rsps();
        join
        drivers_done = 1'b1;
      end
      // Random back-pressure on the request link and the AXI responses
      while (!drivers_done) begin
        @(posedge clk_i);
        if (bp_en) begin
          req_ready_i <= 1'($urandom % 2);
          b_ready_i <= 1'($urandom % 2);
          r_ready_i <= 1'($urandom % 2);
        end
      end
    join
    @(posedge clk_i);
    req_ready_i <= 1'b1;
    b_ready_i <= 1'b1;
    r_ready_i <= 1'b1;
    cycles = 0;
    while (got_req.size() < n_req && cycles < TimeoutCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (got_req.size() < n_req) begin
      $display("Timeout: only %0d of %0d request flits left the link", got_req.size(), n_req);
      errors++;
    end
    // Let any stray flit show up before the counts are compared
    repeat (4) @(posedge clk_i);
    check_requests(n_req);
    check_responses();
    if (errors == errs_at_start) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %0d %s: %0d request flits, %0d response beats, back-pressure %0d",
             test_num, (errors == errs_at_start) ? "passed" : "failed", n_req, n_rsp, bp_en);
    aw_q.delete();
    d0_q.delete();
    ar_q.delete();
    rsp_q.delete();
    exp_aww.delete();
    exp_ar.delete();
    exp_b.delete();
    exp_r.delete();
  endtask

  initial begin
    int          fd;
    bit          have_test;
    string       line;
    logic [7:0]  kind;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    have_test = 1'b0;
    reset_i <= 1'b1;
    id_i <= SrcNode;
    aw_i <= '0;
    aw_valid_i <= 1'b0;
    w_i <= '0;
    w_valid_i <= 1'b0;
    ar_i <= '0;
    ar_valid_i <= 1'b0;
    b_ready_i <= 1'b1;
    r_ready_i <= 1'b1;
    req_ready_i <= 1'b1;
    rsp_flit_i <= '0;
    rsp_valid_i <= 1'b0;
    void'($urandom(54));
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    fd = $fopen("dv/floo_ni_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/floo_ni_stim.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        kind = 8'h00;
        void'($sscanf(line, "%c %h %h %h %h %h", kind, f0, f1, f2, f3, f4));
        case (kind)
          "T": begin
            if (have_test) begin
              run_test();
            end
            have_test = 1'b1;
            bp_en = f0[0];
          end
          "W": add_write(f0, f1, f2, f3, f4);
          "A": add_read(f0, f1, f2, f3);
          "B": add_b(f0, f1);
          "R": add_r(f0, f1, f2, f3);
          // Comments and blank lines
          default: ;
        endcase
      end
      $fclose(fd);
      if (have_test) begin
        run_test();
      end
    end
    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && tests_passed > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- flist.f
hdl/axi_types_pkg.sv
hdl/floo_noc_pkg.sv
hdl/floo_addr_decode.sv
hdl/floo_req_packer.sv
hdl/floo_wormhole_arbiter.sv
hdl/floo_rsp_unpacker.sv
hdl/floo_ni_top.sv
dv/tb_floo_ni.sv

//--- hdl/axi_types_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI channel types
// Widths and packed channel structs for the AW, W, AR, B and R
// channels of the manager port
//////////////////////////////////////////////////////////////////////

package axi_types_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 8;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned RespWidth = 2;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } axi_aw_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } axi_w_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } axi_ar_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [RespWidth-1:0] resp;
  } axi_b_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic [RespWidth-1:0] resp;
    logic                 last;
  } axi_r_t;

endpackage

//--- hdl/floo_addr_decode.sv
//////////////////////////////////////////////////////////////////////
// Address decoder
// Looks up the destination node of an AXI address in the system
// address map, with a fallback node for unmapped addresses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module floo_addr_decode (
  input  logic [axi_types_pkg::AddrWidth-1:0] addr_i,
  output floo_noc_pkg::node_id_t              dst_o
);

  import floo_noc_pkg::*;

  logic hit;

  // First matching rule wins
  always_comb begin
    hit   = 1'b0;
    dst_o = DefaultNode;
    for (int i = 0; i < NumSamRules; i++) begin
      if (!hit && (addr_i >= Sam[i].start_addr) && (addr_i < Sam[i].end_addr)) begin
        hit   = 1'b1;
        dst_o = Sam[i].node;
      end
    end
  end

endmodule

//--- hdl/floo_ni_top.sv
//////////////////////////////////////////////////////////////////////
// Network interface top
// AXI manager port to NoC request and response links
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module floo_ni_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  floo_noc_pkg::node_id_t  id_i,
  // AXI manager side
  input  axi_types_pkg::axi_aw_t  aw_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  axi_types_pkg::axi_w_t   w_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  axi_types_pkg::axi_ar_t  ar_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output axi_types_pkg::axi_b_t   b_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output axi_types_pkg::axi_r_t   r_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  // Network links
  output floo_noc_pkg::req_flit_t req_flit_o,
  output logic                    req_valid_o,
  input  logic                    req_ready_i,
  input  floo_noc_pkg::rsp_flit_t rsp_flit_i,
  input  logic                    rsp_valid_i,
  output logic                    rsp_ready_o
);

  floo_noc_pkg::node_id_t          aw_dst, ar_dst;
  // Stream 0 carries AW/W, stream 1 carries AR
  floo_noc_pkg::req_flit_t [1:0]   arb_flit;
  logic                    [1:0]   arb_valid, arb_ready;

  floo_addr_decode i_aw_decode (
    .addr_i ( aw_i.addr ),
    .dst_o  ( aw_dst    )
  );

  floo_addr_decode i_ar_decode (
    .addr_i ( ar_i.addr ),
    .dst_o  ( ar_dst    )
  );

  floo_req_packer i_req_packer (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .id_i        ( id_i         ),
    .aw_i        ( aw_i         ),
    .aw_valid_i  ( aw_valid_i   ),
    .aw_ready_o  ( aw_ready_o   ),
    .w_i         ( w_i          ),
    .w_valid_i   ( w_valid_i    ),
    .w_ready_o   ( w_ready_o    ),
    .ar_i        ( ar_i         ),
    .ar_valid_i  ( ar_valid_i   ),
    .ar_ready_o  ( ar_ready_o   ),
    .aw_dst_i    ( aw_dst       ),
    .ar_dst_i    ( ar_dst       ),
    .aww_flit_o  ( arb_flit[0]  ),
    .aww_valid_o ( arb_valid[0] ),
    .aww_ready_i ( arb_ready[0] ),
    .ar_flit_o   ( arb_flit[1]  ),
    .ar_valid_o  ( arb_valid[1] ),
    .ar_ready_i  ( arb_ready[1] )
  );

  floo_wormhole_arbiter i_req_arbiter (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .valid_i ( arb_valid   ),
    .ready_o ( arb_ready   ),
    .flit_i  ( arb_flit    ),
    .flit_o  ( req_flit_o  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i )
  );

  floo_rsp_unpacker i_rsp_unpacker (
    .rsp_flit_i  ( rsp_flit_i  ),
    .rsp_valid_i ( rsp_valid_i ),
    .rsp_ready_o ( rsp_ready_o ),
    .b_o         ( b_o         ),
    .b_valid_o   ( b_valid_o   ),
    .b_ready_i   ( b_ready_i   ),
    .r_o         ( r_o         ),
    .r_valid_o   ( r_valid_o   ),
    .r_ready_i   ( r_ready_i   )
  );

endmodule

//--- hdl/floo_noc_pkg.sv
//////////////////////////////////////////////////////////////////////
// NoC types
// Node IDs, system address map, channel codes and the request and
// response flit formats of the network interface
//////////////////////////////////////////////////////////////////////

package floo_noc_pkg;

  import axi_types_pkg::*;

  localparam int unsigned NodeIdWidth = 4;
  typedef logic [NodeIdWidth-1:0] node_id_t;

  ////////////////////////////////////////////////////////////////////
  // System address map
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned NumSamRules = 4;
  localparam node_id_t    DefaultNode = node_id_t'(15);

  // End address is exclusive
  typedef struct packed {
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
    node_id_t             node;
  } sam_rule_t;

  localparam sam_rule_t Sam [NumSamRules] = '{
    '{start_addr: 32'h0000_0000, end_addr: 32'h1000_0000, node: node_id_t'(1)},
    '{start_addr: 32'h1000_0000, end_addr: 32'h2000_0000, node: node_id_t'(2)},
    '{start_addr: 32'h2000_0000, end_addr: 32'h4000_0000, node: node_id_t'(5)},
    '{start_addr: 32'h8000_0000, end_addr: 32'h9000_0000, node: node_id_t'(9)}
  };

  ////////////////////////////////////////////////////////////////////
  // Flits
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    AxiAw,
    AxiW,
    AxiAr,
    AxiB,
    AxiR
  } axi_ch_e;

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } flit_hdr_t;

  // Payload fields are sized for the widest channel on each link
  localparam int unsigned AxPayloadWidth =
    ($bits(axi_aw_t) > $bits(axi_ar_t)) ? $bits(axi_aw_t) : $bits(axi_ar_t);
  localparam int unsigned ReqPayloadWidth =
    (AxPayloadWidth > $bits(axi_w_t)) ? AxPayloadWidth : $bits(axi_w_t);
  localparam int unsigned RspPayloadWidth =
    ($bits(axi_r_t) > $bits(axi_b_t)) ? $bits(axi_r_t) : $bits(axi_b_t);

  typedef struct packed {
    flit_hdr_t                  hdr;
    logic [ReqPayloadWidth-1:0] payload;
  } req_flit_t;

  typedef struct packed {
    flit_hdr_t                  hdr;
    logic [RspPayloadWidth-1:0] payload;
  } rsp_flit_t;

endpackage

//--- hdl/floo_req_packer.sv
//////////////////////////////////////////////////////////////////////
// Request packer
// Packs AXI AW, W and AR beats into request flits; AW and its W
// beats share one stream so a write leaves as a single packet
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module floo_req_packer (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  floo_noc_pkg::node_id_t    id_i,
  input  axi_types_pkg::axi_aw_t    aw_i,
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  axi_types_pkg::axi_w_t     w_i,
  input  logic                      w_valid_i,
  output logic                      w_ready_o,
  input  axi_types_pkg::axi_ar_t    ar_i,
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  input  floo_noc_pkg::node_id_t    aw_dst_i,
  input  floo_noc_pkg::node_id_t    ar_dst_i,
  output floo_noc_pkg::req_flit_t   aww_flit_o,
  output logic                      aww_valid_o,
  input  logic                      aww_ready_i,
  output floo_noc_pkg::req_flit_t   ar_flit_o,
  output logic                      ar_valid_o,
  input  logic                      ar_ready_i
);

  import floo_noc_pkg::*;

  typedef enum logic {SelAw, SelW} aw_w_sel_e;

  aw_w_sel_e aw_w_sel_q, aw_w_sel_d;
  node_id_t  w_dst_q;
  req_flit_t aw_flit, w_flit;

  ////////////////////////////////////////////////////////////////////
  // Flit packing
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    aw_flit.hdr.dst_id = aw_dst_i;
    aw_flit.hdr.src_id = id_i;
    aw_flit.hdr.axi_ch = AxiAw;
    // Packet continues with the W beats
    aw_flit.hdr.last   = 1'b0;
    aw_flit.payload    = ReqPayloadWidth'(aw_i);
  end

  always_comb begin
    w_flit.hdr.dst_id = w_dst_q;
    w_flit.hdr.src_id = id_i;
    w_flit.hdr.axi_ch = AxiW;
    w_flit.hdr.last   = w_i.last;
    w_flit.payload    = ReqPayloadWidth'(w_i);
  end

  always_comb begin
    ar_flit_o.hdr.dst_id = ar_dst_i;
    ar_flit_o.hdr.src_id = id_i;
    ar_flit_o.hdr.axi_ch = AxiAr;
    ar_flit_o.hdr.last   = 1'b1;
    ar_flit_o.payload    = ReqPayloadWidth'(ar_i);
  end

  ////////////////////////////////////////////////////////////////////
  // AW/W sequencing
  ////////////////////////////////////////////////////////////////////

  assign aww_flit_o  = (aw_w_sel_q == SelAw) ? aw_flit : w_flit;
  assign aww_valid_o = (aw_w_sel_q == SelAw) ? aw_valid_i : w_valid_i;
  assign aw_ready_o  = (aw_w_sel_q == SelAw) && aww_ready_i;
  assign w_ready_o   = (aw_w_sel_q == SelW) && aww_ready_i;

  assign ar_valid_o = ar_valid_i;
  assign ar_ready_o = ar_ready_i;

  always_comb begin
    aw_w_sel_d = aw_w_sel_q;
    if (aw_valid_i && aw_ready_o) begin
      aw_w_sel_d = SelW;
    end
    if (w_valid_i && w_ready_o && w_i.last) begin
      aw_w_sel_d = SelAw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_w_sel_q <= SelAw;
    end else begin
      aw_w_sel_q <= aw_w_sel_d;
    end
  end

  // W beats follow the destination of their AW
  always_ff @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      w_dst_q <= aw_dst_i;
    end
  end

endmodule

//--- hdl/floo_rsp_unpacker.sv
//////////////////////////////////////////////////////////////////////
// Response unpacker
// Steers response flits from the network to the AXI B or R channel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module floo_rsp_unpacker (
  input  floo_noc_pkg::rsp_flit_t rsp_flit_i,
  input  logic                    rsp_valid_i,
  output logic                    rsp_ready_o,
  output axi_types_pkg::axi_b_t   b_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output axi_types_pkg::axi_r_t   r_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i
);

  import axi_types_pkg::*;
  import floo_noc_pkg::*;

  logic is_b, is_r;

  assign is_b = (rsp_flit_i.hdr.axi_ch == AxiB);
  assign is_r = (rsp_flit_i.hdr.axi_ch == AxiR);

  // Payload sits in the low bits of the flit
  assign b_o = axi_b_t'(rsp_flit_i.payload[$bits(axi_b_t)-1:0]);
  assign r_o = axi_r_t'(rsp_flit_i.payload[$bits(axi_r_t)-1:0]);

  assign b_valid_o = rsp_valid_i && is_b;
  assign r_valid_o = rsp_valid_i && is_r;

  always_comb begin
    if (is_b) begin
      rsp_ready_o = b_ready_i;
    end else if (is_r) begin
      rsp_ready_o = r_ready_i;
    end else begin
      // Stray request codes are sunk so the link cannot stall
      rsp_ready_o = 1'b1;
    end
  end

endmodule

//--- hdl/floo_wormhole_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Wormhole arbiter
// Round-robin between two flit streams onto one registered link;
// a granted stream keeps the link until its last flit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module floo_wormhole_arbiter (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                    [1:0] valid_i,
  output logic                    [1:0] ready_o,
  input  floo_noc_pkg::req_flit_t [1:0] flit_i,
  output floo_noc_pkg::req_flit_t       flit_o,
  output logic                          valid_o,
  input  logic                          ready_i
);

  import floo_noc_pkg::*;

  req_flit_t out_q;
  logic      out_valid_q;
  logic      lock_q, lock_idx_q;
  logic      rr_q;
  logic      space;
  logic      gnt_idx, gnt_valid;
  logic      take;

  // Output stage frees up in the same cycle its flit leaves
  assign space = !out_valid_q || ready_i;

  always_comb begin
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end else if (valid_i[rr_q]) begin
      gnt_idx = rr_q;
    end else begin
      gnt_idx = !rr_q;
    end
    gnt_valid = valid_i[gnt_idx];
  end

  assign take       = space && gnt_valid;
  assign ready_o[0] = take && (gnt_idx == 1'b0);
  assign ready_o[1] = take && (gnt_idx == 1'b1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q       <= '0;
      out_valid_q <= 1'b0;
      lock_q      <= 1'b0;
      lock_idx_q  <= 1'b0;
      rr_q        <= 1'b0;
    end else if (take) begin
      out_q       <= flit_i[gnt_idx];
      out_valid_q <= 1'b1;
      lock_q      <= !flit_i[gnt_idx].hdr.last;
      lock_idx_q  <= gnt_idx;
      // Hand priority to the other stream once a packet is complete
      if (flit_i[gnt_idx].hdr.last) begin
        rr_q <= !gnt_idx;
      end
    end else if (ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  assign flit_o  = out_q;
  assign valid_o = out_valid_q;

endmodule
